// ==== sources.f ====
+incdir+logic
logic/desPkg.sv
logic/desSbox.sv
logic/desFeistel.sv
logic/desKeySchedule.sv
logic/desRoundCore.sv
logic/desTop.sv
tests/tbDesTop.sv

// ==== tests/tbDesTop.sv ====
`timescale 1ns/1ps
`include "des_cfg.svh"

module tbDesTop;
    import desPkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_RANDOM = 200;
    localparam int LATENCY = `DES_ROUNDS + 1;
    localparam int DONE_LIMIT = 40;
    // two blocks per random pair, a few directed blocks, idle gaps
    localparam int BLOCK_COUNT = 2 * NUM_RANDOM + 6;
    localparam int WATCHDOG_CYCLES = BLOCK_COUNT * 20 + 200;
    localparam keyT KAT_KEY = 64'h133457799BBCDFF1;
    localparam blockT KAT_PLAIN = 64'h0123456789ABCDEF;
    localparam blockT KAT_CIPHER = 64'h85E813540F0AB405;

    logic  clk;
    logic  rst;
    logic  start;
    logic  decrypt;
    keyT   keyIn;
    blockT dataIn;
    logic  busy;
    logic  done;
    blockT dataOut;

    logic [31:0] lfsrState;
    int          checkCount;
    int          errorCount;
    int          testChecks;
    int          testErrors;
    keyT         keys [0:NUM_RANDOM-1];
    blockT       plains [0:NUM_RANDOM-1];
    blockT       ciphers [0:NUM_RANDOM-1];
    blockT       got;

    desTop u_dut
    (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .decrypt (decrypt),
        .keyIn   (keyIn),
        .dataIn  (dataIn),
        .busy    (busy),
        .done    (done),
        .dataOut (dataOut)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, simulation stopped", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    // taps 32, 22, 2, 1
    function automatic logic nextBit();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] randomWord();
        logic [63:0] v;
        for (int i = 0; i < 64; i++)
        begin
            v = {v[62:0], nextBit()};
        end
        return v;
    endfunction

    function automatic halfT feistelModel(input halfT r, input subkeyT k);
        subkeyT x;
        halfT   s;
        halfT   p;
        logic [5:0] six;
        for (int i = 0; i < 48; i++)
        begin
            x[47-i] = r[32 - eTable[i]];
        end
        x = x ^ k;
        for (int b = 0; b < 8; b++)
        begin
            six = x[47-6*b -: 6];
            s[31-4*b -: 4] = sboxTables[b+1][{six[5], six[0], six[4:1]}];
        end
        for (int i = 0; i < 32; i++)
        begin
            p[31-i] = s[32 - pTable[i]];
        end
        return p;
    endfunction

    // full key expansion up front and reversed subkey order for decrypt
    function automatic blockT desModel(input keyT key, input blockT data, input logic dec);
        logic [55:0] cd;
        subkeyT ks [0:15];
        blockT blk;
        blockT res;
        halfT  l;
        halfT  r;
        halfT  t;
        for (int i = 0; i < 56; i++)
        begin
            cd[55-i] = key[64 - pc1Table[i]];
        end
        for (int rnd = 0; rnd < 16; rnd++)
        begin
            for (int n = 0; n < shiftTable[rnd]; n++)
            begin
                cd = {cd[54:28], cd[55], cd[26:0], cd[27]};
            end
            for (int i = 0; i < 48; i++)
            begin
                ks[rnd][47-i] = cd[56 - pc2Table[i]];
            end
        end
        for (int i = 0; i < 64; i++)
        begin
            blk[63-i] = data[64 - ipTable[i]];
        end
        l = blk[63:32];
        r = blk[31:0];
        for (int rnd = 0; rnd < 16; rnd++)
        begin
            t = r;
            r = l ^ feistelModel(r, ks[dec ? 15 - rnd : rnd]);
            l = t;
        end
        blk = {r, l};
        for (int i = 0; i < 64; i++)
        begin
            res[63-i] = blk[64 - fpTable[i]];
        end
        return res;
    endfunction

    task automatic checkEqual(input string what, input logic [63:0] exp, input logic [63:0] act);
        checkCount++;
        assert (act === exp)
        else
        begin
            $display("FAIL t=%0t %s: expected %h, got %h", $time, what, exp, act);
            errorCount++;
        end
    endtask

    task automatic beginTest();
        testChecks = checkCount;
        testErrors = errorCount;
    endtask

    task automatic endTest(input string name);
        $display("test %s: %0d checks, %0d errors", name, checkCount - testChecks,
                 errorCount - testErrors);
    endtask

    // one block through the core with its timing checked
    task automatic runBlock(input keyT key, input blockT data, input logic dec,
                            input logic pokeStart, output blockT result);
        int   cycles;
        logic timedOut;
        timedOut = 1'b0;
        @(negedge clk);
        start = 1'b1;
        decrypt = dec;
        keyIn = key;
        dataIn = data;
        @(negedge clk);
        // inputs must not matter once the block is accepted
        start = 1'b0;
        decrypt = ~dec;
        keyIn = ~key;
        dataIn = ~data;
        cycles = 0;
        while (done !== 1'b1 && !timedOut)
        begin
            checkEqual("busy while in flight", 1, busy);
            start = pokeStart && (cycles == 5);
            if (cycles >= DONE_LIMIT)
            begin
                timedOut = 1'b1;
            end
            else
            begin
                @(negedge clk);
                cycles++;
            end
        end
        start = 1'b0;
        if (timedOut)
        begin
            $display("ERROR: no done pulse within %0d cycles of start at t=%0t",
                     DONE_LIMIT, $time);
            errorCount++;
        end
        else
        begin
            checkEqual("cycles from start to done", LATENCY, cycles);
            checkEqual("busy at done", 0, busy);
        end
        result = dataOut;
        @(negedge clk);
        checkEqual("done width", 0, done);
        checkEqual("dataOut held after done", result, dataOut);
    endtask

    initial
    begin
        lfsrState = 32'he7236e52;
        checkCount = 0;
        errorCount = 0;
        rst = 1'b1;
        start = 1'b0;
        decrypt = 1'b0;
        keyIn = '0;
        dataIn = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        beginTest();
        checkEqual("busy after reset", 0, busy);
        checkEqual("done after reset", 0, done);
        checkEqual("dataOut after reset", 0, dataOut);
        endTest("reset");

        beginTest();
        checkEqual("model known answer", KAT_CIPHER, desModel(KAT_KEY, KAT_PLAIN, 1'b0));
        runBlock(KAT_KEY, KAT_PLAIN, 1'b0, 1'b0, got);
        checkEqual("known-answer encrypt", KAT_CIPHER, got);
        runBlock(KAT_KEY, KAT_CIPHER, 1'b1, 1'b0, got);
        checkEqual("known-answer decrypt", KAT_PLAIN, got);
        endTest("known answer");

        beginTest();
        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            keys[i] = randomWord();
            plains[i] = randomWord();
            runBlock(keys[i], plains[i], 1'b0, 1'b0, got);
            ciphers[i] = got;
            checkEqual("random encrypt", desModel(keys[i], plains[i], 1'b0), got);
        end
        endTest("random encrypt");

        beginTest();
        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            runBlock(keys[i], ciphers[i], 1'b1, 1'b0, got);
            checkEqual("round trip", plains[i], got);
        end
        endTest("round trip");

        beginTest();
        runBlock(KAT_KEY, KAT_PLAIN, 1'b0, 1'b1, got);
        checkEqual("result with start while busy", KAT_CIPHER, got);
        // the ignored start must not launch a second block
        repeat (20)
        begin
            @(negedge clk);
            checkEqual("done after ignored start", 0, done);
            checkEqual("busy after ignored start", 0, busy);
            checkEqual("dataOut held while idle", KAT_CIPHER, dataOut);
        end
        endTest("ignored start");

        $display("total: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0)
        begin
            $display("Done: no errors");
        end
        else
        begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== logic/desTop.sv ====
`timescale 1ns/1ps

module desTop
(
    input  logic          clk,
    input  logic          rst,
    input  logic          start,
    input  logic          decrypt,
    input  desPkg::keyT   keyIn,
    input  desPkg::blockT dataIn,
    output logic          busy,
    output logic          done,
    output desPkg::blockT dataOut
);
    import desPkg::*;

    logic   keyLoad;
    logic   keyStep;
    logic   keyDecrypt;
    roundT  round;
    halfT   feistelIn;
    halfT   fOut;
    subkeyT subkey;

    desRoundCore u_core
    (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .decrypt    (decrypt),
        .dataIn     (dataIn),
        .fOut       (fOut),
        .keyLoad    (keyLoad),
        .keyStep    (keyStep),
        .keyDecrypt (keyDecrypt),
        .round      (round),
        .feistelIn  (feistelIn),
        .busy       (busy),
        .done       (done),
        .dataOut    (dataOut)
    );

    // key is only sampled on the load strobe
    desKeySchedule u_keys
    (
        .clk     (clk),
        .rst     (rst),
        .load    (keyLoad),
        .step    (keyStep),
        .decrypt (keyDecrypt),
        .keyIn   (keyIn),
        .round   (round),
        .subkey  (subkey)
    );

    desFeistel u_feistel
    (
        .rightHalf (feistelIn),
        .subkey    (subkey),
        .fOut      (fOut)
    );

endmodule

// ==== logic/desRoundCore.sv ====
`timescale 1ns/1ps
`include "des_cfg.svh"

module desRoundCore
(
    input  logic          clk,
    input  logic          rst,
    input  logic          start,
    input  logic          decrypt,
    input  desPkg::blockT dataIn,
    input  desPkg::halfT  fOut,
    output logic          keyLoad,
    output logic          keyStep,
    output logic          keyDecrypt,
    output desPkg::roundT round,
    output desPkg::halfT  feistelIn,
    output logic          busy,
    output logic          done,
    output desPkg::blockT dataOut
);
    import desPkg::*;

    localparam roundT LAST_ROUND = roundT'(`DES_ROUNDS - 1);

    coreStateT  state;
    roundStateT lr;
    logic       decryptQ;
    blockT      ipBlock;
    blockT      preOutput;
    blockT      fpBlock;

    always_comb
    begin
        for (int i = 0; i < `DES_BLOCK_W; i++)
        begin
            ipBlock[`DES_BLOCK_W-1-i] = dataIn[`DES_BLOCK_W - ipTable[i]];
        end
    end

    // last round is left unswapped, so swap before FP
    assign preOutput = {lr.right, lr.left};

    always_comb
    begin
        for (int i = 0; i < `DES_BLOCK_W; i++)
        begin
            fpBlock[`DES_BLOCK_W-1-i] = preOutput[`DES_BLOCK_W - fpTable[i]];
        end
    end

    assign feistelIn = lr.right;
    assign keyLoad = (state == IDLE) && start;
    // no rotation needed after round 16
    assign keyStep = (state == ROUNDS) && (round != LAST_ROUND);
    assign keyDecrypt = (state == IDLE) ? decrypt : decryptQ;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= IDLE;
            round    <= '0;
            decryptQ <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            dataOut  <= '0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (start)
                    begin
                        state    <= ROUNDS;
                        round    <= '0;
                        decryptQ <= decrypt;
                        busy     <= 1'b1;
                    end
                end
                ROUNDS:
                begin
                    if (round == LAST_ROUND)
                    begin
                        state <= FINISH;
                    end
                    else
                    begin
                        round <= round + 1'b1;
                    end
                end
                FINISH:
                begin
                    dataOut <= fpBlock;
                    done    <= 1'b1;
                    busy    <= 1'b0;
                    state   <= IDLE;
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // L/R register
    always_ff @(posedge clk)
    begin
        if (keyLoad)
        begin
            lr <= ipBlock;
        end
        else if (state == ROUNDS)
        begin
            lr <= '{left: lr.right, right: lr.left ^ fOut};
        end
    end

    doneSingleCycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("round core: done held longer than one cycle");

    busyDoneExclusive: assert property (@(posedge clk) disable iff (rst) !(busy && done))
        else $error("round core: busy and done high together");

    // full walk of the round counter from load to done
    roundSequence: assert property (@(posedge clk) disable iff (rst)
        keyLoad |=> (state == ROUNDS && round == '0) ##15
                    (state == ROUNDS && round == LAST_ROUND) ##1
                    (state == FINISH) ##1 done)
        else $error("round core: round counter left its 0..15 sequence");

endmodule

// ==== logic/desKeySchedule.sv ====
`timescale 1ns/1ps
`include "des_cfg.svh"

module desKeySchedule
(
    input  logic           clk,
    input  logic           rst,
    input  logic           load,
    input  logic           step,
    input  logic           decrypt,
    input  desPkg::keyT    keyIn,
    input  desPkg::roundT  round,
    output desPkg::subkeyT subkey
);
    import desPkg::*;

    localparam int CD_W = 28;

    logic [2*CD_W-1:0] pc1Key;
    logic [2*CD_W-1:0] cdJoined;
    logic [CD_W-1:0]   cReg;
    logic [CD_W-1:0]   dReg;
    roundT             nextIdx;
    int                shiftAmount;

    function automatic logic [CD_W-1:0] rotl(input logic [CD_W-1:0] v, input int n);
        return (v << n) | (v >> (CD_W - n));
    endfunction

    function automatic logic [CD_W-1:0] rotr(input logic [CD_W-1:0] v, input int n);
        return (v >> n) | (v << (CD_W - n));
    endfunction

    always_comb
    begin
        for (int i = 0; i < 2 * CD_W; i++)
        begin
            pc1Key[2*CD_W-1-i] = keyIn[`DES_KEY_W - pc1Table[i]];
        end
    end

    // decrypt walks the table backwards, from round 16 down
    assign nextIdx = decrypt ? roundT'(`DES_ROUNDS - 1 - round) : roundT'(round + 1'b1);
    assign shiftAmount = shiftTable[nextIdx];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cReg <= '0;
            dReg <= '0;
        end
        else if (load)
        begin
            // C0,D0 already give K16 when decrypting
            if (decrypt)
            begin
                cReg <= pc1Key[2*CD_W-1:CD_W];
                dReg <= pc1Key[CD_W-1:0];
            end
            else
            begin
                cReg <= rotl(pc1Key[2*CD_W-1:CD_W], shiftTable[0]);
                dReg <= rotl(pc1Key[CD_W-1:0], shiftTable[0]);
            end
        end
        else if (step)
        begin
            cReg <= decrypt ? rotr(cReg, shiftAmount) : rotl(cReg, shiftAmount);
            dReg <= decrypt ? rotr(dReg, shiftAmount) : rotl(dReg, shiftAmount);
        end
    end

    assign cdJoined = {cReg, dReg};

    always_comb
    begin
        for (int i = 0; i < `DES_SUBKEY_W; i++)
        begin
            subkey[`DES_SUBKEY_W-1-i] = cdJoined[2*CD_W - pc2Table[i]];
        end
    end

    // strobes come from the round core FSM
    loadStepExclusive: assert property (@(posedge clk) disable iff (rst) !(load && step))
        else $error("key schedule: load and step asserted together");

endmodule

// ==== logic/desFeistel.sv ====
`timescale 1ns/1ps
`include "des_cfg.svh"

module desFeistel
(
    input  desPkg::halfT   rightHalf,
    input  desPkg::subkeyT subkey,
    output desPkg::halfT   fOut
);
    import desPkg::*;

    subkeyT expanded;
    subkeyT mixed;
    halfT   sboxOut;

    // E expansion, 32 to 48 bits
    always_comb
    begin
        for (int i = 0; i < `DES_SUBKEY_W; i++)
        begin
            expanded[`DES_SUBKEY_W-1-i] = rightHalf[`DES_HALF_W - eTable[i]];
        end
    end

    assign mixed = expanded ^ subkey;

    // group 0 takes the top six bits and feeds S1
    genvar g;
    generate
        for (g = 0; g < 8; g++)
        begin : genSbox
            desSbox
            #(
                .BOX_INDEX (g + 1)
            )
            u_sbox
            (
                .bitsIn    (mixed[`DES_SUBKEY_W-1-6*g -: 6]),
                .nibbleOut (sboxOut[`DES_HALF_W-1-4*g -: 4])
            );
        end
    endgenerate

    // P permutation of the concatenated nibbles
    always_comb
    begin
        for (int i = 0; i < `DES_HALF_W; i++)
        begin
            fOut[`DES_HALF_W-1-i] = sboxOut[`DES_HALF_W - pTable[i]];
        end
    end

endmodule

// ==== logic/desSbox.sv ====
`timescale 1ns/1ps

module desSbox
#(
    parameter int BOX_INDEX = 6
)
(
    input  logic [5:0] bitsIn,
    output logic [3:0] nibbleOut
);
    import desPkg::*;

    logic [5:0] tableIndex;

    if (BOX_INDEX < 1 || BOX_INDEX > 8)
    begin : genBadIndex
        $error("desSbox: BOX_INDEX must lie in 1..8");
    end

    // row from the outer bits, column from the inner four
    assign tableIndex = {bitsIn[5], bitsIn[0], bitsIn[4:1]};

    assign nibbleOut = sboxTables[BOX_INDEX][tableIndex];

endmodule

// ==== logic/desPkg.sv ====
`include "des_cfg.svh"

package desPkg;

    typedef logic [`DES_BLOCK_W-1:0] blockT;
    typedef logic [`DES_KEY_W-1:0] keyT;
    typedef logic [`DES_HALF_W-1:0] halfT;
    typedef logic [`DES_SUBKEY_W-1:0] subkeyT;
    typedef logic [$clog2(`DES_ROUNDS)-1:0] roundT;

    // left half sits in the upper 32 bits
    typedef struct packed {
        halfT left;
        halfT right;
    } roundStateT;

    typedef enum logic [1:0] {
        IDLE,
        ROUNDS,
        FINISH
    } coreStateT;

    // nibble 0 is the leftmost hex digit, index is {row, column}
    typedef logic [0:63][3:0] sboxT;

    // S1 to S8, one row of 16 entries per underscore group
    localparam sboxT sboxTables [1:8] = '{
        256'hE4D12FB83A6C5907_0F74E2D1A6CB9538_41E8D62BFC973A50_FC8249175B3EA06D,
        256'hF18E6B34972DC05A_3D47F28EC01A69B5_0E7BA4D158C6932F_D8A13F42B67C05E9,
        256'hA09E63F51DC7B428_D70934A6285ECBF1_D6498F30B12C5AE7_1AD069874FE3B52C,
        256'h7DE3069A1285BC4F_D8B56F03472C1AE9_A690CB7DF13E5284_3F06A1D8945BC72E,
        256'h2C417AB6853FD0E9_EB2C47D150FA3986_421BAD78F9C5630E_B8C71E2D6F09A453,
        256'hC1AF92680D34E75B_AF427C9561DE0B38_9EF528C3704A1DB6_432C95FABE17608D,
        256'h4B2EF08D3C975A61_D0B7491AE35C2F86_14BDC37EAF680592_6BD814A7950FE23C,
        256'hD2846FB1A93E50C7_1FD8A374C56B0E92_7B419CE206ADF358_21E74A8DFC90356B
    };

    // source bit numbers, counted from 1 at the MSB as in the standard
    localparam int ipTable [0:63] = '{
        58, 50, 42, 34, 26, 18, 10, 2,
        60, 52, 44, 36, 28, 20, 12, 4,
        62, 54, 46, 38, 30, 22, 14, 6,
        64, 56, 48, 40, 32, 24, 16, 8,
        57, 49, 41, 33, 25, 17, 9, 1,
        59, 51, 43, 35, 27, 19, 11, 3,
        61, 53, 45, 37, 29, 21, 13, 5,
        63, 55, 47, 39, 31, 23, 15, 7
    };

    localparam int fpTable [0:63] = '{
        40, 8, 48, 16, 56, 24, 64, 32,
        39, 7, 47, 15, 55, 23, 63, 31,
        38, 6, 46, 14, 54, 22, 62, 30,
        37, 5, 45, 13, 53, 21, 61, 29,
        36, 4, 44, 12, 52, 20, 60, 28,
        35, 3, 43, 11, 51, 19, 59, 27,
        34, 2, 42, 10, 50, 18, 58, 26,
        33, 1, 41, 9, 49, 17, 57, 25
    };

    localparam int eTable [0:47] = '{
        32, 1, 2, 3, 4, 5,
        4, 5, 6, 7, 8, 9,
        8, 9, 10, 11, 12, 13,
        12, 13, 14, 15, 16, 17,
        16, 17, 18, 19, 20, 21,
        20, 21, 22, 23, 24, 25,
        24, 25, 26, 27, 28, 29,
        28, 29, 30, 31, 32, 1
    };

    localparam int pTable [0:31] = '{
        16, 7, 20, 21, 29, 12, 28, 17,
        1, 15, 23, 26, 5, 18, 31, 10,
        2, 8, 24, 14, 32, 27, 3, 9,
        19, 13, 30, 6, 22, 11, 4, 25
    };

    // parity bits 8, 16 .. 64 never appear here
    localparam int pc1Table [0:55] = '{
        57, 49, 41, 33, 25, 17, 9,
        1, 58, 50, 42, 34, 26, 18,
        10, 2, 59, 51, 43, 35, 27,
        19, 11, 3, 60, 52, 44, 36,
        63, 55, 47, 39, 31, 23, 15,
        7, 62, 54, 46, 38, 30, 22,
        14, 6, 61, 53, 45, 37, 29,
        21, 13, 5, 28, 20, 12, 4
    };

    localparam int pc2Table [0:47] = '{
        14, 17, 11, 24, 1, 5,
        3, 28, 15, 6, 21, 10,
        23, 19, 12, 4, 26, 8,
        16, 7, 27, 20, 13, 2,
        41, 52, 31, 37, 47, 55,
        30, 40, 51, 45, 33, 48,
        44, 49, 39, 56, 34, 53,
        46, 42, 50, 36, 29, 32
    };

    // rotations sum to 28, one full turn of C and D
    localparam int shiftTable [0:15] = '{
        1, 1, 2, 2, 2, 2, 2, 2,
        1, 2, 2, 2, 2, 2, 2, 1
    };

endpackage

// ==== logic/des_cfg.svh ====
`ifndef DES_CFG_SVH
`define DES_CFG_SVH

// block and key sizes in bits
`define DES_BLOCK_W 64
// key width counts the eight parity bits
`define DES_KEY_W 64
`define DES_HALF_W 32
`define DES_SUBKEY_W 48

// one round per clock in the iterative core
`define DES_ROUNDS 16

`endif
